/* sim.f */
common/core_pkg.sv
rtl/pipe_ctrl.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/exec_stage.sv
rtl/mem_stage.sv
trace/trace_unit.sv
rtl/core_top.sv
tb/core_tb.sv

/* Bender.yml */
package:
  name: core_trace

sources:
  - common/core_pkg.sv
  - rtl/pipe_ctrl.sv
  - rtl/fetch_stage.sv
  - rtl/decode_stage.sv
  - rtl/exec_stage.sv
  - rtl/mem_stage.sv
  - trace/trace_unit.sv
  - rtl/core_top.sv
  - target: test
    files:
      - tb/core_tb.sv

/* tb/core_tb.sv */
module core_tb;

  import core_pkg::*;

  localparam int PROG_LEN   = 25;
  localparam int MAX_REC    = 32;
  localparam int DMEM_WORDS = 64;
  localparam int WAIT_LIMIT = 40;  // Cycles allowed between two records.

  logic       clk = 1'b0;
  logic       rst;
  instr_t     imem_data;
  data_t      imem_addr;
  trace_rec_t trace;
  logic       trace_valid;

  logic [15:0] prog [PROG_LEN];

  // Expected record for each retired instruction in program order.
  logic [15:0] exp_pc    [MAX_REC];
  logic        exp_we    [MAX_REC];
  logic [2:0]  exp_rd    [MAX_REC];
  logic [15:0] exp_data  [MAX_REC];
  int          exp_stall [MAX_REC];
  int          exp_fetch [MAX_REC];
  int          exp_issue [MAX_REC];
  int          exp_cnt;

  int   cycle;
  int   tests;
  int   fail_cnt;
  logic rec_fail;

  core_top i_core_top (
    .clk, .rst, .imem_data, .imem_addr, .trace, .trace_valid
  );

  always #4 clk = ~clk;

  // Instruction memory returns NOP past the end of the program.
  assign imem_data = (imem_addr < PROG_LEN) ? prog[imem_addr] : 16'h0000;

  function automatic logic [15:0] enc_r(opcode_t op, int rd, int rs1, int rs2);
    return {op, 3'(rd), 3'(rs1), 3'(rs2), 3'b000};
  endfunction

  function automatic logic [15:0] enc_i(opcode_t op, int rd, int rs1, int imm);
    return {op, 3'(rd), 3'(rs1), 6'(imm)};
  endfunction

  task automatic load_program();
    prog[0]  = enc_i(OP_ADDI, 1, 0, 5);
    prog[1]  = enc_i(OP_ADDI, 2, 0, 3);
    prog[2]  = enc_i(OP_ADDI, 3, 0, -2);
    prog[3]  = 16'h0000;
    prog[4]  = 16'h0000;
    prog[5]  = enc_r(OP_ADD, 4, 1, 2);   // Independent ALU ops.
    prog[6]  = enc_r(OP_SUB, 5, 1, 2);
    prog[7]  = enc_r(OP_AND, 6, 1, 3);
    prog[8]  = enc_r(OP_OR, 7, 2, 3);
    prog[9]  = enc_i(OP_ADDI, 1, 1, 1);
    prog[10] = enc_r(OP_ADD, 2, 1, 1);   // Distance one on r1.
    prog[11] = enc_r(OP_SUB, 3, 2, 4);   // Distance one on r2.
    prog[12] = 16'h0000;
    prog[13] = enc_i(OP_ADDI, 5, 3, 7);  // Distance two on r3.
    prog[14] = enc_i(OP_ST, 5, 0, 4);
    prog[15] = enc_i(OP_ADDI, 6, 0, 9);
    prog[16] = enc_i(OP_LD, 7, 0, 4);
    prog[17] = enc_r(OP_ADD, 4, 7, 7);
    prog[18] = enc_i(OP_BEQ, 7, 5, 2);   // Taken branch to 21.
    prog[19] = enc_i(OP_ADDI, 1, 0, 31);
    prog[20] = enc_i(OP_ADDI, 2, 0, 31);
    prog[21] = enc_i(OP_ADDI, 1, 1, -6);
    prog[22] = enc_i(OP_BEQ, 0, 2, 3);   // Not taken.
    prog[23] = enc_r(OP_OR, 3, 1, 6);
    prog[24] = enc_r(OP_ADD, 0, 3, 6);
  endtask

  // Sequential ISA model with the interlock timing on top.
  task automatic run_model();
    logic [15:0] mreg [8];
    logic [15:0] mmem [DMEM_WORDS];
    int          ready [8];   // First cycle a reader of the register may issue.
    logic [15:0] pc;
    logic [15:0] w;
    logic [15:0] imm;
    logic [15:0] addr;
    logic [15:0] res;
    opcode_t     op;
    int          rd;
    int          rs1;
    int          src2;
    int          t_prev;
    int          f;
    int          t;
    logic        is_r;
    logic        use2;
    logic        we;
    logic        jumped;
    for (int r = 0; r < 8; r++) begin
      mreg[r]  = '0;
      ready[r] = 0;
    end
    pc      = '0;
    t_prev  = 0;
    jumped  = 1'b0;
    exp_cnt = 0;
    while (pc < PROG_LEN && exp_cnt < MAX_REC) begin
      w    = prog[pc];
      op   = opcode_t'(w[15:12]);
      rd   = w[11:9];
      rs1  = w[8:6];
      imm  = {{10{w[5]}}, w[5:0]};
      addr = mreg[rs1] + imm;
      is_r = (op == OP_ADD) || (op == OP_SUB) || (op == OP_AND) || (op == OP_OR);
      src2 = is_r ? int'(w[5:3]) : rd;
      use2 = is_r || (op == OP_ST) || (op == OP_BEQ);
      // A taken branch refetches two cycles after its own issue.
      f = jumped ? t_prev + 2 : t_prev;
      t = f + 1;
      if (op != OP_NOP && ready[rs1] > t) t = ready[rs1];
      if (use2 && ready[src2] > t) t = ready[src2];
      we     = 1'b1;
      res    = '0;
      jumped = 1'b0;
      case (op)
        OP_ADD:  res = mreg[rs1] + mreg[src2];
        OP_SUB:  res = mreg[rs1] - mreg[src2];
        OP_AND:  res = mreg[rs1] & mreg[src2];
        OP_OR:   res = mreg[rs1] | mreg[src2];
        OP_ADDI: res = addr;
        OP_LD:   res = mmem[addr % DMEM_WORDS];
        OP_ST: begin
          mmem[addr % DMEM_WORDS] = mreg[rd];
          we = 1'b0;
        end
        OP_BEQ: begin
          jumped = (mreg[rs1] == mreg[rd]);
          we     = 1'b0;
        end
        default: we = 1'b0;
      endcase
      exp_pc[exp_cnt]    = pc;
      exp_we[exp_cnt]    = we;
      exp_rd[exp_cnt]    = 3'(rd);
      exp_data[exp_cnt]  = res;
      exp_stall[exp_cnt] = t - f - 1;
      exp_fetch[exp_cnt] = f;
      exp_issue[exp_cnt] = t;
      if (we) begin
        mreg[rd]  = res;
        ready[rd] = t + 3;  // Readers may issue in the write-back cycle.
      end
      pc      = jumped ? pc + 16'd1 + imm : pc + 16'd1;
      t_prev  = t;
      exp_cnt = exp_cnt + 1;
    end
  endtask

  task automatic compare_field(int idx, string name, logic [15:0] got, logic [15:0] exp);
    if (got !== exp) begin
      $display("Error: record %0d %s = 0x%h, expected 0x%h", idx, name, got, exp);
      rec_fail = 1'b1;
    end
  endtask

  task automatic check_record(int k);
    rec_fail = 1'b0;
    compare_field(k, "trace_valid cycle", 16'(cycle), 16'(exp_issue[k] + 4));
    compare_field(k, "trace.tag", 16'(trace.tag), 16'(k % 16));
    compare_field(k, "trace.instr", trace.instr, prog[exp_pc[k]]);
    compare_field(k, "trace.fetch_stamp", trace.fetch_stamp, 16'(exp_fetch[k]));
    compare_field(k, "issue-fetch", trace.issue_stamp - trace.fetch_stamp,
                  16'(exp_stall[k] + 1));
    compare_field(k, "trace.issue_stamp", trace.issue_stamp, 16'(exp_issue[k]));
    compare_field(k, "trace.ex_stamp", trace.ex_stamp, 16'(exp_issue[k] + 1));
    compare_field(k, "trace.mem_stamp", trace.mem_stamp, 16'(exp_issue[k] + 2));
    compare_field(k, "trace.wb_stamp", trace.wb_stamp, 16'(exp_issue[k] + 3));
    compare_field(k, "trace.we", 16'(trace.we), 16'(exp_we[k]));
    compare_field(k, "trace.rd", 16'(trace.rd), 16'(exp_rd[k]));
    if (exp_we[k]) begin
      compare_field(k, "trace.data", trace.data, exp_data[k]);
    end
    tests = tests + 1;
    if (rec_fail) fail_cnt = fail_cnt + 1;
    $display("Record %2d pc 0x%h stalls %0d: %s", k, exp_pc[k], exp_stall[k],
             rec_fail ? "fail" : "ok");
  endtask

  initial begin
    int waited;
    rst      = 1'b1;
    tests    = 0;
    fail_cnt = 0;
    load_program();
    run_model();

    rec_fail = 1'b0;
    for (int c = 0; c < 4; c++) begin
      @(negedge clk);
      compare_field(-1, "trace_valid", 16'(trace_valid), 16'h0000);
      compare_field(-1, "imem_addr", imem_addr, 16'h0000);
    end
    rst   = 1'b0;
    cycle = 0;  // First cycle after reset.
    tests = tests + 1;
    if (rec_fail) fail_cnt = fail_cnt + 1;
    $display("Reset state: %s", rec_fail ? "fail" : "ok");

    for (int k = 0; k < exp_cnt; k++) begin
      waited = 0;
      do begin
        @(negedge clk);
        cycle  = cycle + 1;
        waited = waited + 1;
      end while (trace_valid !== 1'b1 && waited < WAIT_LIMIT);
      if (trace_valid !== 1'b1) begin
        $display("Timeout: trace record %0d did not appear within %0d cycles",
                 k, WAIT_LIMIT);
        tests    = tests + 1;
        fail_cnt = fail_cnt + 1;
        break;
      end
      check_record(k);
    end

    $display("Summary: %0d tests, %0d passed, %0d failed", tests, tests - fail_cnt,
             fail_cnt);
    if (fail_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* rtl/core_top.sv */
module core_top #(
  parameter int TRACE_DEPTH = 8,
  parameter int DMEM_WORDS  = 64
) (
  input  logic                 clk,
  input  logic                 rst,
  input  core_pkg::instr_t     imem_data,
  output core_pkg::data_t      imem_addr,
  output core_pkg::trace_rec_t trace,
  output logic                 trace_valid
);

  import core_pkg::*;

  // Control.
  logic       stall;
  logic       flush;
  reg_idx_t   src_a;
  reg_idx_t   src_b;
  logic       use_a;
  logic       use_b;

  // IF/ID.
  instr_t     id_instr;
  data_t      id_pc;
  logic       id_valid;
  logic       fetch_load;

  // ID/EX.
  instr_t     ex_instr;
  data_t      ex_pc;
  data_t      ex_a;
  data_t      ex_b;
  logic       ex_valid;
  tag_t       ex_tag;
  issue_evt_t issue;
  logic       issue_valid;

  // EX/MEM and branch.
  logic       branch_taken;
  data_t      branch_target;
  reg_idx_t   ex_rd;
  logic       ex_we;
  instr_t     mem_instr;
  data_t      mem_alu;
  data_t      mem_store;
  logic       mem_valid;
  tag_t       mem_tag;

  // MEM/WB.
  reg_idx_t   mem_rd;
  logic       mem_we;
  wb_evt_t    wb;
  logic       wb_valid;

  pipe_ctrl i_pipe_ctrl (
    .clk, .rst, .src_a, .src_b, .use_a, .use_b,
    .ex_rd, .mem_rd, .ex_we, .mem_we, .branch_taken,
    .stall, .flush
  );

  fetch_stage i_fetch_stage (
    .clk, .rst, .stall, .flush, .branch_target, .imem_data,
    .imem_addr, .id_instr, .id_pc, .id_valid, .fetch_load
  );

  decode_stage i_decode_stage (
    .clk, .rst, .stall, .flush, .id_instr, .id_pc, .id_valid, .wb, .wb_valid,
    .src_a, .src_b, .use_a, .use_b, .ex_instr, .ex_pc, .ex_a, .ex_b,
    .ex_valid, .ex_tag, .issue, .issue_valid
  );

  exec_stage i_exec_stage (
    .clk, .rst, .ex_instr, .ex_pc, .ex_a, .ex_b, .ex_valid, .ex_tag,
    .branch_taken, .branch_target, .ex_rd, .ex_we,
    .mem_instr, .mem_alu, .mem_store, .mem_valid, .mem_tag
  );

  mem_stage #(
    .DMEM_WORDS(DMEM_WORDS)
  ) i_mem_stage (
    .clk, .rst, .mem_instr, .mem_alu, .mem_store, .mem_valid, .mem_tag,
    .mem_rd, .mem_we, .wb, .wb_valid
  );

  trace_unit #(
    .TRACE_DEPTH(TRACE_DEPTH)
  ) i_trace_unit (
    .clk, .rst, .fetch_load, .issue, .issue_valid,
    .ex_valid, .ex_tag, .mem_valid, .mem_tag, .wb, .wb_valid, .flush,
    .trace, .trace_valid
  );

endmodule

/* trace/trace_unit.sv */
module trace_unit #(
  parameter int TRACE_DEPTH = 8
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 fetch_load,
  input  core_pkg::issue_evt_t issue,
  input  logic                 issue_valid,
  input  logic                 ex_valid,
  input  core_pkg::tag_t       ex_tag,
  input  logic                 mem_valid,
  input  core_pkg::tag_t       mem_tag,
  input  core_pkg::wb_evt_t    wb,
  input  logic                 wb_valid,
  input  logic                 flush,
  output core_pkg::trace_rec_t trace,
  output logic                 trace_valid
);

  import core_pkg::*;

  localparam int IW = $clog2(TRACE_DEPTH);

  stamp_t cycle_cnt;
  stamp_t fetch_pend;  // Fetch cycle of the word in IF/ID.
  logic [TRACE_DEPTH-1:0] busy;

  // Trace table, one entry per instruction in flight.
  instr_t tab_instr [TRACE_DEPTH];
  stamp_t tab_fetch [TRACE_DEPTH];
  stamp_t tab_issue [TRACE_DEPTH];
  stamp_t tab_ex    [TRACE_DEPTH];
  stamp_t tab_mem   [TRACE_DEPTH];

  logic [IW-1:0] issue_idx;
  logic [IW-1:0] ex_idx;
  logic [IW-1:0] mem_idx;
  logic [IW-1:0] wb_idx;

  assign issue_idx = issue.tag[IW-1:0];
  assign ex_idx    = ex_tag[IW-1:0];
  assign mem_idx   = mem_tag[IW-1:0];
  assign wb_idx    = wb.tag[IW-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      cycle_cnt   <= '0;
      fetch_pend  <= '0;
      busy        <= '0;
      trace_valid <= 1'b0;
    end else begin
      cycle_cnt   <= cycle_cnt + 16'd1;
      trace_valid <= wb_valid;
      // A held word keeps the cycle of its first fetch.
      if (flush) begin
        fetch_pend <= '0;
      end else if (fetch_load) begin
        fetch_pend <= cycle_cnt;
      end
      if (wb_valid) begin
        busy[wb_idx] <= 1'b0;
      end
      if (issue_valid) begin
        busy[issue_idx] <= 1'b1;
      end
    end
  end

  // Table fill.
  always_ff @(posedge clk) begin
    if (issue_valid) begin
      tab_instr[issue_idx] <= issue.instr;
      tab_fetch[issue_idx] <= fetch_pend;
      tab_issue[issue_idx] <= cycle_cnt;
    end
    if (ex_valid && busy[ex_idx]) begin
      tab_ex[ex_idx] <= cycle_cnt;
    end
    if (mem_valid && busy[mem_idx]) begin
      tab_mem[mem_idx] <= cycle_cnt;
    end
  end

  // Record out at write-back.
  always_ff @(posedge clk) begin
    if (wb_valid) begin
      trace.tag         <= wb.tag;
      trace.instr       <= tab_instr[wb_idx];
      trace.fetch_stamp <= tab_fetch[wb_idx];
      trace.issue_stamp <= tab_issue[wb_idx];
      trace.ex_stamp    <= tab_ex[wb_idx];
      trace.mem_stamp   <= tab_mem[wb_idx];
      trace.wb_stamp    <= cycle_cnt;
      trace.we          <= wb.we;
      trace.rd          <= wb.rd;
      trace.data        <= wb.data;
    end
  end

endmodule

/* rtl/mem_stage.sv */
module mem_stage #(
  parameter int DMEM_WORDS = 64
) (
  input  logic               clk,
  input  logic               rst,
  input  core_pkg::instr_t   mem_instr,
  input  core_pkg::data_t    mem_alu,
  input  core_pkg::data_t    mem_store,
  input  logic               mem_valid,
  input  core_pkg::tag_t     mem_tag,
  output core_pkg::reg_idx_t mem_rd,
  output logic               mem_we,
  output core_pkg::wb_evt_t  wb,
  output logic               wb_valid
);

  import core_pkg::*;

  localparam int AW = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

  opcode_t       op;
  logic [AW-1:0] addr;
  data_t         dmem [DMEM_WORDS];
  data_t         ld_data;

  assign op     = mem_instr.r.op;
  assign addr   = AW'(mem_alu % DMEM_WORDS);  // Word address.
  assign mem_rd = mem_instr.r.rd;
  assign mem_we = mem_valid && writes_rd(op);

  assign ld_data = dmem[addr];

  always_ff @(posedge clk) begin
    if (mem_valid && (op == OP_ST)) begin
      dmem[addr] <= mem_store;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= mem_valid;
    end
  end

  // MEM/WB payload.
  always_ff @(posedge clk) begin
    wb.tag  <= mem_tag;
    wb.we   <= writes_rd(op);
    wb.rd   <= mem_rd;
    wb.data <= (op == OP_LD) ? ld_data : mem_alu;
  end

endmodule

/* rtl/exec_stage.sv */
module exec_stage (
  input  logic               clk,
  input  logic               rst,
  input  core_pkg::instr_t   ex_instr,
  input  core_pkg::data_t    ex_pc,
  input  core_pkg::data_t    ex_a,
  input  core_pkg::data_t    ex_b,
  input  logic               ex_valid,
  input  core_pkg::tag_t     ex_tag,
  output logic               branch_taken,
  output core_pkg::data_t    branch_target,
  output core_pkg::reg_idx_t ex_rd,
  output logic               ex_we,
  output core_pkg::instr_t   mem_instr,
  output core_pkg::data_t    mem_alu,
  output core_pkg::data_t    mem_store,
  output logic               mem_valid,
  output core_pkg::tag_t     mem_tag
);

  import core_pkg::*;

  opcode_t op;
  data_t   imm_ext;
  data_t   alu_res;

  assign op      = ex_instr.r.op;
  assign imm_ext = {{10{ex_instr.i.imm[5]}}, ex_instr.i.imm};

  always_comb begin
    case (op)
      OP_ADD:  alu_res = ex_a + ex_b;
      OP_SUB:  alu_res = ex_a - ex_b;
      OP_AND:  alu_res = ex_a & ex_b;
      OP_OR:   alu_res = ex_a | ex_b;
      default: alu_res = ex_a + imm_ext;  // ADDI, and the LD/ST address.
    endcase
  end

  assign branch_taken  = ex_valid && (op == OP_BEQ) && (ex_a == ex_b);
  assign branch_target = ex_pc + 16'd1 + imm_ext;

  assign ex_rd = ex_instr.r.rd;
  assign ex_we = ex_valid && writes_rd(op);

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_valid <= 1'b0;
    end else begin
      mem_valid <= ex_valid;
    end
  end

  // EX/MEM payload.
  always_ff @(posedge clk) begin
    mem_instr <= ex_instr;
    mem_alu   <= alu_res;
    mem_store <= ex_b;     // Store data comes from rd.
    mem_tag   <= ex_tag;
  end

endmodule

/* rtl/decode_stage.sv */
module decode_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 stall,
  input  logic                 flush,
  input  core_pkg::instr_t     id_instr,
  input  core_pkg::data_t      id_pc,
  input  logic                 id_valid,
  input  core_pkg::wb_evt_t    wb,
  input  logic                 wb_valid,
  output core_pkg::reg_idx_t   src_a,
  output core_pkg::reg_idx_t   src_b,
  output logic                 use_a,
  output logic                 use_b,
  output core_pkg::instr_t     ex_instr,
  output core_pkg::data_t      ex_pc,
  output core_pkg::data_t      ex_a,
  output core_pkg::data_t      ex_b,
  output logic                 ex_valid,
  output core_pkg::tag_t       ex_tag,
  output core_pkg::issue_evt_t issue,
  output logic                 issue_valid
);

  import core_pkg::*;

  opcode_t op;
  logic    is_r;
  logic    rd_as_src;  // ST and BEQ compare or store rd.
  data_t   regs [8];
  data_t   rd_a;
  data_t   rd_b;
  tag_t    tag_q;

  assign op        = id_instr.r.op;
  assign is_r      = (op == OP_ADD) || (op == OP_SUB) || (op == OP_AND) || (op == OP_OR);
  assign rd_as_src = (op == OP_ST) || (op == OP_BEQ);

  assign src_a = id_instr.r.rs1;
  assign src_b = is_r ? id_instr.r.rs2 : id_instr.i.rd;
  assign use_a = id_valid && (is_r || rd_as_src || (op == OP_ADDI) || (op == OP_LD));
  assign use_b = id_valid && (is_r || rd_as_src);

  // Register file with write-through to the read ports.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < 8; r++) begin
        regs[r] <= '0;
      end
    end else if (wb_valid && wb.we) begin
      regs[wb.rd] <= wb.data;
    end
  end

  assign rd_a = (wb_valid && wb.we && (wb.rd == src_a)) ? wb.data : regs[src_a];
  assign rd_b = (wb_valid && wb.we && (wb.rd == src_b)) ? wb.data : regs[src_b];

  assign issue_valid = id_valid && !stall && !flush;
  assign issue.tag         = tag_q;
  assign issue.instr       = id_instr;
  assign issue.fetch_stamp = '0;  // The trace unit holds the fetch stamp.

  // A bubble enters ID/EX on stall or flush.
  always_ff @(posedge clk) begin
    if (rst) begin
      tag_q    <= '0;
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= issue_valid;
      if (issue_valid) begin
        tag_q <= tag_q + 4'd1;
      end
    end
  end

  // ID/EX payload.
  always_ff @(posedge clk) begin
    if (issue_valid) begin
      ex_instr <= id_instr;
      ex_pc    <= id_pc;
      ex_a     <= rd_a;
      ex_b     <= rd_b;
      ex_tag   <= tag_q;
    end
  end

endmodule

/* rtl/fetch_stage.sv */
module fetch_stage (
  input  logic             clk,
  input  logic             rst,
  input  logic             stall,
  input  logic             flush,
  input  core_pkg::data_t  branch_target,
  input  core_pkg::instr_t imem_data,
  output core_pkg::data_t  imem_addr,
  output core_pkg::instr_t id_instr,
  output core_pkg::data_t  id_pc,
  output logic             id_valid,
  output logic             fetch_load
);

  import core_pkg::*;

  data_t pc;

  assign imem_addr  = pc;
  assign fetch_load = !stall && !flush;  // IF/ID takes a new word.

  // PC and IF/ID valid.
  always_ff @(posedge clk) begin
    if (rst) begin
      pc       <= '0;
      id_valid <= 1'b0;
    end else if (flush) begin
      pc       <= branch_target;
      id_valid <= 1'b0;  // Squash the slot in IF.
    end else if (!stall) begin
      pc       <= pc + 16'd1;
      id_valid <= 1'b1;
    end
  end

  // IF/ID payload.
  always_ff @(posedge clk) begin
    if (fetch_load) begin
      id_instr <= imem_data;
      id_pc    <= pc;
    end
  end

endmodule

/* rtl/pipe_ctrl.sv */
module pipe_ctrl (
  input  logic              clk,
  input  logic              rst,
  input  core_pkg::reg_idx_t src_a,
  input  core_pkg::reg_idx_t src_b,
  input  logic              use_a,
  input  logic              use_b,
  input  core_pkg::reg_idx_t ex_rd,
  input  core_pkg::reg_idx_t mem_rd,
  input  logic              ex_we,
  input  logic              mem_we,
  input  logic              branch_taken,
  output logic              stall,
  output logic              flush
);

  logic hazard_a;
  logic hazard_b;
  logic flush_q;  // High in the cycle after a flush.

  // Write-back is not checked, the register file writes through.
  assign hazard_a = use_a &&
                    ((ex_we && (ex_rd == src_a)) || (mem_we && (mem_rd == src_a)));
  assign hazard_b = use_b &&
                    ((ex_we && (ex_rd == src_b)) || (mem_we && (mem_rd == src_b)));

  // The squashed slot cannot branch, but keep a second flush out anyway.
  assign flush = branch_taken && !flush_q;

  // Flush wins over stall.
  assign stall = (hazard_a || hazard_b) && !flush;

  always_ff @(posedge clk) begin
    if (rst) begin
      flush_q <= 1'b0;
    end else begin
      flush_q <= flush;
    end
  end

endmodule

/* common/core_pkg.sv */
package core_pkg;

  typedef logic [15:0] data_t;
  typedef logic [2:0]  reg_idx_t;
  typedef logic [3:0]  tag_t;     // Issue order, wraps at 16.
  typedef logic [15:0] stamp_t;   // Cycle count.

  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_OR   = 4'd4,
    OP_ADDI = 4'd5,
    OP_LD   = 4'd6,
    OP_ST   = 4'd7,
    OP_BEQ  = 4'd8
  } opcode_t;

  // Register format.
  typedef struct packed {
    opcode_t    op;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic [2:0] spare;
  } instr_r_t;

  // Immediate format, also used by LD, ST and BEQ.
  typedef struct packed {
    opcode_t           op;
    reg_idx_t          rd;
    reg_idx_t          rs1;
    logic signed [5:0] imm;
  } instr_i_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_t;

  typedef struct packed {
    tag_t   tag;
    instr_t instr;
    stamp_t fetch_stamp;
  } issue_evt_t;

  typedef struct packed {
    tag_t     tag;
    logic     we;
    reg_idx_t rd;
    data_t    data;
  } wb_evt_t;

  typedef struct packed {
    tag_t     tag;
    instr_t   instr;
    stamp_t   fetch_stamp;
    stamp_t   issue_stamp;
    stamp_t   ex_stamp;
    stamp_t   mem_stamp;
    stamp_t   wb_stamp;
    logic     we;
    reg_idx_t rd;
    data_t    data;
  } trace_rec_t;

  // Opcodes that write a destination register.
  function automatic logic writes_rd(opcode_t op);
    case (op)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI, OP_LD: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage
